//--- hdl/cache_pkg.sv
package cache_pkg;

    localparam int sets  = 256;
    localparam int banks = 4;

    typedef logic [7:0]   index_t;
    typedef logic [19:0]  tag_t;
    typedef logic [3:0]   offset_t;
    typedef logic [1:0]   bank_sel_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   wstrb_t;
    // bank 0 in the low word
    typedef logic [127:0] line_t;

    // one cpu access, op 1 is a store
    typedef struct packed {
        logic    op;
        index_t  index;
        tag_t    tag;
        offset_t offset;
        wstrb_t  wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // bank write into one way
    typedef struct packed {
        index_t    index;
        bank_sel_t bank;
        wstrb_t    wstrb;
        word_t     wdata;
    } way_wr_t;

    typedef enum logic [2:0] {
        main_idle,
        main_lookup,
        main_miss,
        main_replace,
        main_refill
    } main_state_t;

    typedef enum logic {
        wb_idle,
        wb_write
    } wb_state_t;

endpackage

//--- hdl/cache_sram.sv
`timescale 1ns/1ns

module cache_sram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256,
    parameter int STRB  = 4
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [STRB-1:0]          wen,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    // bits covered by one write enable
    localparam int LANE = WIDTH / STRB;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < STRB; i++) begin
            if (wen[i]) begin
                mem[addr][i*LANE +: LANE] <= wdata[i*LANE +: LANE];
            end
        end
    end

    // read returns the old contents on a write to the same address
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- hdl/cache_way.sv
`timescale 1ns/1ns

module cache_way (
    input  logic                clk,
    input  logic                resetn,
    input  cache_pkg::index_t   rd_index,
    input  logic                tagv_wen,
    input  cache_pkg::tagv_t    tagv_wdata,
    input  cache_pkg::way_wr_t  bank_wr,
    input  logic                bank_wen,
    input  logic                dirty_set,
    input  logic                dirty_clr,
    output cache_pkg::tagv_t    tagv,
    output cache_pkg::line_t    line,
    output logic                dirty
);

    import cache_pkg::*;

    tagv_t           tag_q;
    word_t           bank_q [banks];
    logic [sets-1:0] valid_tab;
    logic [sets-1:0] dirty_tab;
    logic            valid_q;

    // tag store, always addressed by the read index
    cache_sram #(
        .WIDTH ($bits(tagv_t)),
        .DEPTH (sets),
        .STRB  (1)
    ) i_tagv_ram (
        .clk   (clk),
        .addr  (rd_index),
        .wen   (tagv_wen),
        .wdata (tagv_wdata),
        .rdata (tag_q)
    );

    for (genvar b = 0; b < banks; b++) begin : g_bank
        logic   sel;
        index_t addr;
        wstrb_t wen;

        // a write takes the port of its own bank only
        assign sel  = bank_wen && (bank_wr.bank == bank_sel_t'(b));
        assign addr = sel ? bank_wr.index : rd_index;
        assign wen  = sel ? bank_wr.wstrb : '0;

        cache_sram #(
            .WIDTH ($bits(word_t)),
            .DEPTH (sets),
            .STRB  ($bits(wstrb_t))
        ) i_bank_ram (
            .clk   (clk),
            .addr  (addr),
            .wen   (wen),
            .wdata (bank_wr.wdata),
            .rdata (bank_q[b])
        );
    end

    always_comb begin
        for (int b = 0; b < banks; b++) begin
            line[b*32 +: 32] = bank_q[b];
        end
    end

    // valid mask lets reset drop the whole way at once
    assign tagv = '{tag: tag_q.tag, valid: tag_q.valid && valid_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_tab <= '0;
            dirty_tab <= '0;
            valid_q   <= 1'b0;
            dirty     <= 1'b0;
        end else begin
            if (tagv_wen) begin
                valid_tab[rd_index] <= tagv_wdata.valid;
            end
            if (dirty_set) begin
                dirty_tab[bank_wr.index] <= 1'b1;
            end else if (dirty_clr) begin
                dirty_tab[bank_wr.index] <= 1'b0;
            end
            // same timing as the ram outputs
            valid_q <= valid_tab[rd_index];
            dirty   <= dirty_tab[rd_index];
        end
    end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                clk,
    input  logic                resetn,

    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output cache_pkg::word_t    rdata,

    output cache_pkg::index_t   rd_index [2],
    output logic [1:0]          tagv_wen,
    output cache_pkg::tagv_t    tagv_wdata [2],
    output cache_pkg::way_wr_t  bank_wr [2],
    output logic [1:0]          bank_wen,
    output logic [1:0]          dirty_set,
    output logic [1:0]          dirty_clr,
    input  cache_pkg::tagv_t    tagv [2],
    input  cache_pkg::line_t    line [2],
    input  logic [1:0]          dirty,

    output logic                rd_req,
    output logic [2:0]          rd_type,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    output logic                wr_req,
    output logic [2:0]          wr_type,
    output logic [31:0]         wr_addr,
    output cache_pkg::wstrb_t   wr_wstrb,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    import cache_pkg::*;

    main_state_t state;
    main_state_t state_nxt;
    wb_state_t   wb_state;
    wb_state_t   wb_state_nxt;
    cpu_req_t    req_r;
    logic        accept;
    logic [1:0]  way_hit;
    logic        cache_hit;
    logic        store_hit;
    bank_sel_t   req_bank;
    line_t       hit_line;
    word_t       hit_word;
    logic        hazard;
    index_t      ram_index;
    logic        victim_sel;
    logic        vic_way;
    logic        vic_valid;
    logic        vic_dirty;
    bank_sel_t   ret_cnt;
    logic        ret_hit;
    word_t       merged;
    way_wr_t     fill_wr;
    logic        wb_way;
    way_wr_t     wb_r;

    assign req_bank = req_r.offset[3:2];

    // tag compare in lookup
    assign way_hit[0] = tagv[0].valid && (tagv[0].tag == req_r.tag);
    assign way_hit[1] = tagv[1].valid && (tagv[1].tag == req_r.tag);
    assign cache_hit  = |way_hit;
    assign store_hit  = (state == main_lookup) && cache_hit && req_r.op;
    assign hit_line   = way_hit[1] ? line[1] : line[0];
    assign hit_word   = hit_line[req_bank*32 +: 32];

    // a load must not read a bank with a store still in flight
    assign hazard = !req.op && (
        (store_hit && (req.index == req_r.index) && (req.offset[3:2] == req_bank)) ||
        ((wb_state == wb_write) && (req.offset[3:2] == wb_r.bank)));

    assign addr_ok = ((state == main_idle) || ((state == main_lookup) && cache_hit)) && !hazard;
    assign accept  = valid && addr_ok;

    // rams follow the incoming request until a miss owns them
    assign ram_index = ((state == main_idle) || (state == main_lookup)) ? req.index : req_r.index;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= main_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            main_idle: begin
                if (accept) begin
                    state_nxt = main_lookup;
                end
            end
            main_lookup: begin
                if (!cache_hit) begin
                    state_nxt = main_miss;
                end else if (!accept) begin
                    state_nxt = main_idle;
                end
            end
            main_miss: begin
                if (vic_valid && (!vic_dirty || wr_rdy)) begin
                    state_nxt = main_replace;
                end
            end
            main_replace: begin
                if (rd_rdy) begin
                    state_nxt = main_refill;
                end
            end
            main_refill: begin
                if (ret_valid && ret_last) begin
                    state_nxt = main_idle;
                end
            end
            default: begin
                state_nxt = main_idle;
            end
        endcase
    end

    // victim ram outputs settle one cycle into main_miss
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_sel <= 1'b0;
            vic_valid  <= 1'b0;
            ret_cnt    <= '0;
        end else begin
            if ((state == main_lookup) && !cache_hit) begin
                victim_sel <= !victim_sel;
            end
            vic_valid <= (state == main_miss);
            if (state == main_replace) begin
                ret_cnt <= '0;
            end else if ((state == main_refill) && ret_valid) begin
                ret_cnt <= ret_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == main_lookup) && !cache_hit) begin
            vic_way <= victim_sel;
        end
    end

    assign vic_dirty = dirty[vic_way] && tagv[vic_way].valid;

    // refill word, with a pending store merged in
    assign ret_hit = (state == main_refill) && ret_valid && (ret_cnt == req_bank);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[i*8 +: 8] = (req_r.op && req_r.wstrb[i]) ? req_r.wdata[i*8 +: 8]
                                                             : ret_data[i*8 +: 8];
        end
    end

    assign fill_wr = '{index: req_r.index, bank: ret_cnt, wstrb: 4'hf,
                       wdata: ret_hit ? merged : ret_data};

    // write buffer holds one store hit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_state <= wb_idle;
        end else begin
            wb_state <= wb_state_nxt;
        end
    end

    // a new store hit refills the buffer from either state
    assign wb_state_nxt = store_hit ? wb_write : wb_idle;

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wb_way <= way_hit[1];
            wb_r   <= '{index: req_r.index, bank: req_bank, wstrb: req_r.wstrb,
                        wdata: req_r.wdata};
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd_index[w]   = ram_index;
            bank_wr[w]    = (wb_state == wb_write) ? wb_r : fill_wr;
            tagv_wdata[w] = '{tag: req_r.tag, valid: 1'b1};
            tagv_wen[w]   = (state == main_refill) && ret_valid && ret_last && (vic_way == 1'(w));
            bank_wen[w]   = ((wb_state == wb_write) && (wb_way == 1'(w))) ||
                            ((state == main_refill) && ret_valid && (vic_way == 1'(w)));
            dirty_set[w]  = ((wb_state == wb_write) && (wb_way == 1'(w))) ||
                            (ret_hit && req_r.op && (vic_way == 1'(w)));
            dirty_clr[w]  = (state == main_replace) && rd_rdy && (vic_way == 1'(w));
        end
    end

    assign data_ok = ((state == main_lookup) && cache_hit) || ret_hit;
    assign rdata   = (state == main_refill) ? ret_data : hit_word;

    assign rd_req  = (state == main_replace);
    assign rd_type = 3'b100;
    assign rd_addr = {req_r.tag, req_r.index, 4'b0000};

    // victim line stays on the ram outputs while main_miss holds the index
    assign wr_req   = (state == main_miss) && vic_valid && vic_dirty;
    assign wr_type  = 3'b100;
    assign wr_addr  = {tagv[vic_way].tag, req_r.index, 4'b0000};
    assign wr_wstrb = 4'hf;
    assign wr_data  = line[vic_way];

endmodule

//--- hdl/cache.sv
`timescale 1ns/1ns

module cache (
    input  logic                clk,
    input  logic                resetn,

    // cpu port
    input  logic                valid,
    input  logic                op,
    input  cache_pkg::index_t   index,
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::offset_t  offset,
    input  cache_pkg::wstrb_t   wstrb,
    input  cache_pkg::word_t    wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output cache_pkg::word_t    rdata,

    // memory port
    output logic                rd_req,
    output logic [2:0]          rd_type,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    output logic                wr_req,
    output logic [2:0]          wr_type,
    output logic [31:0]         wr_addr,
    output cache_pkg::wstrb_t   wr_wstrb,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    import cache_pkg::*;

    cpu_req_t   req;
    index_t     rd_index [2];
    logic [1:0] tagv_wen;
    tagv_t      tagv_wdata [2];
    way_wr_t    bank_wr [2];
    logic [1:0] bank_wen;
    logic [1:0] dirty_set;
    logic [1:0] dirty_clr;
    tagv_t      tagv [2];
    line_t      line [2];
    logic [1:0] dirty;

    assign req = '{op: op, index: index, tag: tag, offset: offset, wstrb: wstrb, wdata: wdata};

    cache_ctrl i_ctrl (
        .clk, .resetn,
        .valid, .req, .addr_ok, .data_ok, .rdata,
        .rd_index, .tagv_wen, .tagv_wdata, .bank_wr, .bank_wen,
        .dirty_set, .dirty_clr, .tagv, .line, .dirty,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_wstrb, .wr_data, .wr_rdy
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way i_way (
            .clk        (clk),
            .resetn     (resetn),
            .rd_index   (rd_index[w]),
            .tagv_wen   (tagv_wen[w]),
            .tagv_wdata (tagv_wdata[w]),
            .bank_wr    (bank_wr[w]),
            .bank_wen   (bank_wen[w]),
            .dirty_set  (dirty_set[w]),
            .dirty_clr  (dirty_clr[w]),
            .tagv       (tagv[w]),
            .line       (line[w]),
            .dirty      (dirty[w])
        );
    end

endmodule

//--- verification/cache_checker.sv
`timescale 1ns/1ns

module cache_checker (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  logic        rd_req,
    input  logic        rd_rdy,
    input  logic [31:0] rd_addr,
    input  logic        wr_req,
    input  logic        wr_rdy,
    input  logic [31:0] wr_addr
);

    logic [3:0] pending;
    int         failures = 0;

    // accesses accepted but not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= '0;
        end else begin
            pending <= pending + 4'(valid && addr_ok) - 4'(data_ok);
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> (pending != 0))
    else begin
        $error("data_ok with no accepted access outstanding");
        failures++;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> (rd_req && $stable(rd_addr)))
    else begin
        $error("rd_req dropped or rd_addr changed before rd_rdy");
        failures++;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        (wr_req && !wr_rdy) |=> (wr_req && $stable(wr_addr)))
    else begin
        $error("wr_req dropped or wr_addr changed before wr_rdy");
        failures++;
    end

    assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req))
    else begin
        $error("rd_req and wr_req high together");
        failures++;
    end

endmodule

//--- verification/cache_scoreboard.sv
`timescale 1ns/1ns

module cache_scoreboard (
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  logic         op,
    input  logic [31:0]  addr,
    input  logic [3:0]   wstrb,
    input  logic [31:0]  wdata,
    input  logic         expect_hit,
    input  logic         addr_ok,
    input  logic         data_ok,
    input  logic [31:0]  rdata,
    input  logic         rd_req,
    input  logic         rd_rdy,
    input  logic [2:0]   rd_type,
    input  logic [31:0]  rd_addr,
    input  logic         wr_req,
    input  logic         wr_rdy,
    input  logic [2:0]   wr_type,
    input  logic [31:0]  wr_addr,
    input  logic [3:0]   wr_wstrb,
    input  logic [127:0] wr_data,
    output int           outstanding,
    output int           checks,
    output int           errors
);

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [31:0] expected;
    } access_t;

    access_t     pend [$];
    logic [31:0] shadow [logic [29:0]];
    bit          stored [logic [27:0]];
    logic        hit_due;
    logic        in_reset;

    initial begin
        outstanding = 0;
        checks      = 0;
        errors      = 0;
        hit_due     = 1'b0;
        in_reset    = 1'b1;
    end

    // unwritten words read as their byte address xor a pattern
    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a5a5a;
    endfunction

    function automatic logic [127:0] shadow_line(input logic [31:0] a);
        logic [127:0] l;
        for (int b = 0; b < 4; b++) begin
            l[b*32 +: 32] = shadow_word({a[31:4], 4'(b*4)});
        end
        return l;
    endfunction

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %0h got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        access_t     done_acc;
        logic [31:0] w;
        if (!resetn) begin
            in_reset = 1'b1;
            hit_due  = 1'b0;
        end else begin
            if (in_reset) begin
                compare("addr_ok", 1'b1, addr_ok);
                compare("data_ok", 1'b0, data_ok);
                compare("rd_req", 1'b0, rd_req);
                compare("wr_req", 1'b0, wr_req);
                in_reset = 1'b0;
            end
            if (hit_due && !data_ok) begin
                report("hit was not answered in the cycle after acceptance");
            end
            hit_due = 1'b0;
            if (data_ok) begin
                if (pend.size() == 0) begin
                    report("data_ok with no access pending");
                end else begin
                    done_acc = pend.pop_front();
                    if (!done_acc.op) begin
                        compare("rdata", done_acc.expected, rdata);
                    end
                end
            end
            if (rd_req && rd_rdy) begin
                compare("rd_type", 3'b100, rd_type);
                if (pend.size() == 0) begin
                    report("line read with no access pending");
                end else begin
                    compare("rd_addr", {pend[0].addr[31:4], 4'h0}, rd_addr);
                end
            end
            if (wr_req && wr_rdy) begin
                if (!stored.exists(wr_addr[31:4])) begin
                    report("writeback of a line that was never stored to");
                end
                compare("wr_type", 3'b100, wr_type);
                compare("wr_wstrb", 4'hf, wr_wstrb);
                compare("wr_data", shadow_line(wr_addr), wr_data);
            end
            if (valid && addr_ok) begin
                w = shadow_word(addr);
                if (op) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb[i]) begin
                            w[i*8 +: 8] = wdata[i*8 +: 8];
                        end
                    end
                    shadow[addr[31:2]] = w;
                    stored[addr[31:4]] = 1'b1;
                end
                pend.push_back('{op: op, addr: addr, expected: w});
                hit_due = expect_hit;
            end
            outstanding = pend.size();
        end
    end

endmodule

//--- verification/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        hit;
    } entry_t;

    localparam int wait_limit = 200;

    logic         clk = 1'b0;
    logic         resetn;
    logic         valid;
    logic         op;
    logic [7:0]   index;
    logic [19:0]  tag;
    logic [3:0]   offset;
    logic [3:0]   wstrb;
    logic [31:0]  wdata;
    logic         expect_hit;
    logic         addr_ok;
    logic         data_ok;
    logic [31:0]  rdata;
    logic         rd_req;
    logic [2:0]   rd_type;
    logic [31:0]  rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    logic [31:0]  ret_data;
    logic         wr_req;
    logic [2:0]   wr_type;
    logic [31:0]  wr_addr;
    logic [3:0]   wr_wstrb;
    logic [127:0] wr_data;
    logic         wr_rdy;
    int           outstanding;
    int           checks;
    int           errors;

    entry_t      table_q [$];
    logic [31:0] lfsr = 32'h89d892a8;
    logic [31:0] mem [logic [29:0]];
    bit          timed_out = 1'b0;

    cache i_cache (.*);

    cache_scoreboard i_scoreboard (.*, .addr({tag, index, offset}));

    bind cache_ctrl cache_checker i_checker (.*);

    always #50 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a5a5a;
    endfunction

    function automatic entry_t make_entry(input logic is_store, input logic [19:0] t,
                                          input logic [7:0] idx, input logic [1:0] bank,
                                          input logic [3:0] strb, input logic [31:0] data,
                                          input logic hit_exp);
        return '{op: is_store, addr: {t, idx, bank, 2'b00}, wstrb: strb, wdata: data,
                 hit: hit_exp};
    endfunction

    task automatic build_table();
        logic        r_op;
        logic [7:0]  idx;
        logic [19:0] t;
        logic [1:0]  bank;
        logic [3:0]  strb;
        logic [31:0] data;
        // first touch, hits on the same line, then a load right behind a store
        table_q.push_back(make_entry(0, 20'h00011, 8'h10, 2'd0, 4'h0, 32'h0, 0));
        table_q.push_back(make_entry(0, 20'h00011, 8'h10, 2'd2, 4'h0, 32'h0, 1));
        table_q.push_back(make_entry(1, 20'h00011, 8'h10, 2'd1, 4'b0011, 32'hdeadbeef, 1));
        table_q.push_back(make_entry(0, 20'h00011, 8'h10, 2'd1, 4'h0, 32'h0, 1));
        // store miss allocates
        table_q.push_back(make_entry(1, 20'h00022, 8'h20, 2'd3, 4'b1100, 32'hcafef00d, 0));
        table_q.push_back(make_entry(0, 20'h00022, 8'h20, 2'd3, 4'h0, 32'h0, 1));
        table_q.push_back(make_entry(1, 20'h00022, 8'h20, 2'd0, 4'hf, 32'h13572468, 1));
        // three tags on set 0x30 push dirty lines out
        table_q.push_back(make_entry(1, 20'h000a1, 8'h30, 2'd0, 4'hf, 32'h11112222, 0));
        table_q.push_back(make_entry(1, 20'h000b2, 8'h30, 2'd1, 4'b0101, 32'ha5a5c3c3, 0));
        table_q.push_back(make_entry(0, 20'h000c3, 8'h30, 2'd2, 4'h0, 32'h0, 0));
        table_q.push_back(make_entry(0, 20'h000a1, 8'h30, 2'd0, 4'h0, 32'h0, 0));
        table_q.push_back(make_entry(0, 20'h000b2, 8'h30, 2'd1, 4'h0, 32'h0, 0));
        // back to back hits on consecutive words
        table_q.push_back(make_entry(1, 20'h000a1, 8'h30, 2'd1, 4'hf, 32'h01234567, 1));
        table_q.push_back(make_entry(0, 20'h000a1, 8'h30, 2'd0, 4'h0, 32'h0, 1));
        table_q.push_back(make_entry(1, 20'h000a1, 8'h30, 2'd2, 4'b1000, 32'h89abcdef, 1));
        table_q.push_back(make_entry(0, 20'h000a1, 8'h30, 2'd1, 4'h0, 32'h0, 1));
        table_q.push_back(make_entry(0, 20'h000a1, 8'h30, 2'd2, 4'h0, 32'h0, 1));
        table_q.push_back(make_entry(0, 20'h000b2, 8'h30, 2'd1, 4'h0, 32'h0, 1));
        // random mix over four sets and three tags
        for (int i = 0; i < 48; i++) begin
            r_op = rand_bits(1);
            idx  = 8'h80 + 8'(rand_bits(2));
            t    = 20'h00200 + 20'(rand_bits(2) % 3);
            bank = rand_bits(2);
            strb = rand_bits(4);
            data = rand_bits(32);
            table_q.push_back(make_entry(r_op, t, idx, bank, strb, data, 0));
        end
    endtask

    task automatic apply_entry(input entry_t e);
        int   waited;
        logic taken;
        valid      = 1'b1;
        op         = e.op;
        tag        = e.addr[31:12];
        index      = e.addr[11:4];
        offset     = e.addr[3:0];
        wstrb      = e.wstrb;
        wdata      = e.wdata;
        expect_hit = e.hit;
        waited     = 0;
        taken      = 1'b0;
        while (!taken && waited < wait_limit) begin
            @(posedge clk);
            taken = addr_ok;
            waited++;
        end
        #10;
        valid = 1'b0;
        if (!taken) begin
            timed_out = 1'b1;
            $display("timeout: addr_ok stayed low for %0d cycles at %0t", wait_limit, $time);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (outstanding != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d accesses never saw data_ok", outstanding);
        end
    endtask

    // memory side, one line transfer at a time
    initial begin : memory_model
        int          gap;
        logic [31:0] base;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (resetn && wr_req) begin
                gap = rand_bits(2);
                repeat (gap) @(posedge clk);
                #10 wr_rdy = 1'b1;
                @(posedge clk);
                for (int b = 0; b < 4; b++) begin
                    mem[{wr_addr[31:4], 2'(b)}] = wr_data[b*32 +: 32];
                end
                #10 wr_rdy = 1'b0;
            end else if (resetn && rd_req) begin
                gap = rand_bits(2);
                repeat (gap) @(posedge clk);
                #10 rd_rdy = 1'b1;
                @(posedge clk);
                base = rd_addr;
                #10 rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = mem_word(base + 32'(b * 4));
                    @(posedge clk);
                    #10;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int assert_fails;
        resetn     = 1'b0;
        valid      = 1'b0;
        op         = 1'b0;
        index      = '0;
        tag        = '0;
        offset     = '0;
        wstrb      = '0;
        wdata      = '0;
        expect_hit = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #10 resetn = 1'b1;
        @(posedge clk);
        #10;
        for (int i = 0; i < table_q.size(); i++) begin
            apply_entry(table_q[i]);
            if (timed_out) begin
                break;
            end
        end
        if (!timed_out) begin
            wait_drained();
        end
        assert_fails = i_cache.i_ctrl.i_checker.failures;
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checks, errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- cache.f
hdl/cache_pkg.sv
hdl/cache_sram.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/cache.sv
verification/cache_checker.sv
verification/cache_scoreboard.sv
verification/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_sram.sv
  - hdl/cache_way.sv
  - hdl/cache_ctrl.sv
  - hdl/cache.sv
  - target: test
    files:
      - verification/cache_checker.sv
      - verification/cache_scoreboard.sv
      - verification/cache_tb.sv
